// File: src/MemOpPkg.sv
////////////////////////////////////////////////////////////////////////////
// Micro-op encoding for the memory execution lane. The 24-bit op field is
// read as a memory access or as a CSR access, depending on the op type.
// The offset and the CSR number share the upper 12 bits of the field.
////////////////////////////////////////////////////////////////////////////
`default_nettype none

package MemOpPkg;

    localparam int OffsetWidth = 12;
    localparam int CsrNumberWidth = 12;
    localparam int CsrImmWidth = 5;

    typedef enum logic [1:0] {
        LOAD = 2'd0,
        STORE = 2'd1,
        CSR = 2'd2,
        NOP = 2'd3
    } MemOpType;

    typedef enum logic [1:0] {
        WRITE = 2'd0,
        SET = 2'd1,
        CLEAR = 2'd2
    } CsrCode;

    // Offset is two's complement, sign extended by the address unit
    typedef struct packed {
        logic [OffsetWidth-1:0] offset;
        logic [1:0] size;
        logic isSigned;
        logic [8:0] unused;
    } MemAccessField;

    typedef struct packed {
        logic [CsrNumberWidth-1:0] csrNumber;
        CsrCode code;
        logic isImm;
        logic [CsrImmWidth-1:0] imm;
        logic [3:0] unused;
    } CsrAccessField;

    typedef union packed {
        MemAccessField mem;
        CsrAccessField csr;
    } OpField;

    typedef struct packed {
        MemOpType opType;
        OpField field;
    } MemOp;

endpackage

`default_nettype wire

// File: src/MemMapPkg.sv
////////////////////////////////////////////////////////////////////////////
// Data and address widths plus the memory map. Cachable memory starts at
// zero and ends at MemLimit. The IO window is a module parameter and is
// not defined here.
////////////////////////////////////////////////////////////////////////////
`default_nettype none

package MemMapPkg;

    localparam int DataWidth = 32;

    // Logical address width
    localparam int AddrWidth = 32;

    // Physical address is the low part of the logical one
    localparam int PhyAddrWidth = 28;

    // End of cachable memory, exclusive
    localparam logic [AddrWidth-1:0] MemLimit = 32'h0100_0000;

    typedef enum logic [1:0] {
        MMT_MEMORY = 2'd0,
        MMT_IO = 2'd1,
        MMT_ILLEGAL = 2'd2
    } MemoryMapType;

endpackage

`default_nettype wire

// File: src/MemExecIf.sv
////////////////////////////////////////////////////////////////////////////
// Registered op from the stage to the address unit and the CSR file.
// issue means the op commits this cycle, so CSR writes key on it.
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

interface MemExecIf;
    import MemOpPkg::*;
    import MemMapPkg::*;

    logic valid;
    MemOp op;
    logic [DataWidth-1:0] operandA;
    logic issue;

    modport Stage (
        output valid,
        output op,
        output operandA,
        output issue
    );

    // Address path is purely combinational on the payload
    modport Address (
        input op,
        input operandA
    );

    modport Csr (
        input valid,
        input op,
        input operandA,
        input issue
    );

endinterface

`default_nettype wire

// File: src/AddressUnit.sv
////////////////////////////////////////////////////////////////////////////
// Combinational effective address and memory map lookup. The IO window
// must not overlap cachable memory, since memory is checked first.
// Only the IO window is uncachable.
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module AddressUnit #(
    parameter logic [MemMapPkg::AddrWidth-1:0] IoBase = 32'h4000_0000,
    parameter logic [MemMapPkg::AddrWidth-1:0] IoSize = 32'h0001_0000
) (
    MemExecIf.Address exIf,
    output logic [MemMapPkg::AddrWidth-1:0] addrOut,
    output logic [MemMapPkg::PhyAddrWidth-1:0] phyAddrOut,
    output MemMapPkg::MemoryMapType memMapType,
    output logic uncachable
);
    import MemOpPkg::*;
    import MemMapPkg::*;

    MemAccessField memField;
    logic [AddrWidth-1:0] offsetExt;
    logic [AddrWidth-1:0] ioOffset;
    logic inIoWindow;

    always_comb begin
        memField = exIf.op.field.mem;

        // Base plus sign-extended offset
        offsetExt = {{(AddrWidth-OffsetWidth){memField.offset[OffsetWidth-1]}},
                     memField.offset};
        addrOut = exIf.operandA + offsetExt;
        phyAddrOut = addrOut[PhyAddrWidth-1:0];

        // Offset into the window, so the upper bound never overflows
        ioOffset = addrOut - IoBase;
        inIoWindow = (addrOut >= IoBase) && (ioOffset < IoSize);

        if (addrOut < MemLimit) begin
            memMapType = MMT_MEMORY;
        end else if (inIoWindow) begin
            memMapType = MMT_IO;
        end else begin
            memMapType = MMT_ILLEGAL;
        end

        uncachable = (memMapType == MMT_IO);
    end

endmodule

`default_nettype wire

// File: src/CsrFile.sv
////////////////////////////////////////////////////////////////////////////
// Small CSR bank with read-before-write. The old value is shown in the
// cycle of the access and the update lands at the end of an issue cycle.
// Numbers at or above CsrCount read zero and ignore writes.
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module CsrFile #(
    parameter int CsrCount = 8
) (
    input logic clock,
    input logic reset,
    MemExecIf.Csr exIf,
    output logic [MemMapPkg::DataWidth-1:0] csrReadData
);
    import MemOpPkg::*;
    import MemMapPkg::*;

    localparam int IndexWidth = (CsrCount > 1) ? $clog2(CsrCount) : 1;

    logic [DataWidth-1:0] csrs [CsrCount];

    CsrAccessField csrField;
    logic inRange;
    logic [IndexWidth-1:0] index;
    logic [DataWidth-1:0] oldValue;
    logic [DataWidth-1:0] source;
    logic [DataWidth-1:0] writeData;
    logic writeEnable;

    always_comb begin
        csrField = exIf.op.field.csr;
        inRange = (int'(csrField.csrNumber) < CsrCount);
        index = csrField.csrNumber[IndexWidth-1:0];
        oldValue = inRange ? csrs[index] : '0;

        // Immediate is zero extended
        source = csrField.isImm ? {{(DataWidth-CsrImmWidth){1'b0}}, csrField.imm}
                                : exIf.operandA;

        case (csrField.code)
            WRITE: writeData = source;
            SET: writeData = oldValue | source;
            CLEAR: writeData = oldValue & ~source;
            default: writeData = oldValue;
        endcase

        writeEnable = exIf.valid && exIf.issue && (exIf.op.opType == CSR) && inRange;
    end

    assign csrReadData = oldValue;

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < CsrCount; i++) begin
                csrs[i] <= '0;
            end
        end else if (writeEnable) begin
            csrs[index] <= writeData;
        end
    end

endmodule

`default_nettype wire

// File: src/MemExecStage.sv
////////////////////////////////////////////////////////////////////////////
// Single-lane memory execution stage. Holds one op; stall is the only
// back-pressure. Flush kills the registered op in the same cycle and
// also drops it if the register is being held by a stall.
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module MemExecStage (
    input logic clock,
    input logic reset,
    input logic stall,
    input logic flush,
    input logic inValid,
    input MemOpPkg::MemOp inOp,
    input logic [MemMapPkg::DataWidth-1:0] inOperandA,
    input logic [MemMapPkg::DataWidth-1:0] inOperandB,
    input logic inOpAValid,
    input logic inOpBValid,
    MemExecIf.Stage exIf,
    input logic [MemMapPkg::AddrWidth-1:0] addrOut,
    input logic [MemMapPkg::PhyAddrWidth-1:0] phyAddrOut,
    input MemMapPkg::MemoryMapType memMapType,
    input logic uncachable,
    input logic [MemMapPkg::DataWidth-1:0] csrReadData,
    output logic outValid,
    output logic regValid,
    output logic dcReadReq,
    output logic [MemMapPkg::AddrWidth-1:0] outAddr,
    output logic [MemMapPkg::PhyAddrWidth-1:0] outPhyAddr,
    output logic [MemMapPkg::DataWidth-1:0] outData,
    output MemMapPkg::MemoryMapType outMapType,
    output logic [MemMapPkg::PhyAddrWidth-1:0] dcReadAddr,
    output logic dcReadUncachable
);
    import MemOpPkg::*;
    import MemMapPkg::*;

    logic pipeValid;
    MemOp pipeOp;
    logic [DataWidth-1:0] pipeOperandA;
    logic [DataWidth-1:0] pipeOperandB;
    logic pipeOpAValid;
    logic pipeOpBValid;

    // Valid bit
    always_ff @(posedge clock) begin
        if (reset) begin
            pipeValid <= 1'b0;
        end else if (!stall) begin
            pipeValid <= inValid;
        end else if (flush) begin
            pipeValid <= 1'b0;
        end
    end

    // Payload, held while stalled
    always_ff @(posedge clock) begin
        if (!stall) begin
            pipeOp <= inOp;
            pipeOperandA <= inOperandA;
            pipeOperandB <= inOperandB;
            pipeOpAValid <= inOpAValid;
            pipeOpBValid <= inOpBValid;
        end
    end

    always_comb begin
        // Operand B only matters for stores; a miss here means replay
        regValid = pipeOpAValid && ((pipeOp.opType != STORE) || pipeOpBValid);
        outValid = pipeValid && !stall && !flush;
        dcReadReq = outValid && regValid && (pipeOp.opType == LOAD);

        dcReadAddr = phyAddrOut;
        dcReadUncachable = uncachable;

        outAddr = addrOut;
        outPhyAddr = phyAddrOut;
        outMapType = memMapType;
        outData = (pipeOp.opType == CSR) ? csrReadData : pipeOperandB;
    end

    // Registered op toward the units
    always_comb begin
        exIf.valid = pipeValid;
        exIf.op = pipeOp;
        exIf.operandA = pipeOperandA;
        exIf.issue = outValid && regValid;
    end

endmodule

`default_nettype wire

// File: src/MemExecTop.sv
////////////////////////////////////////////////////////////////////////////
// Memory execution lane with plain ports. Latency is one cycle from the
// accepting edge to outValid.
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module MemExecTop #(
    parameter logic [MemMapPkg::AddrWidth-1:0] IoBase = 32'h4000_0000,
    parameter logic [MemMapPkg::AddrWidth-1:0] IoSize = 32'h0001_0000,
    parameter int CsrCount = 8
) (
    input logic clock,
    input logic reset,
    input logic stall,
    input logic flush,
    input logic inValid,
    input MemOpPkg::MemOp inOp,
    input logic [MemMapPkg::DataWidth-1:0] inOperandA,
    input logic [MemMapPkg::DataWidth-1:0] inOperandB,
    input logic inOpAValid,
    input logic inOpBValid,
    output logic outValid,
    output logic regValid,
    output logic dcReadReq,
    output logic [MemMapPkg::PhyAddrWidth-1:0] dcReadAddr,
    output logic dcReadUncachable,
    output logic [MemMapPkg::AddrWidth-1:0] outAddr,
    output logic [MemMapPkg::PhyAddrWidth-1:0] outPhyAddr,
    output MemMapPkg::MemoryMapType outMapType,
    output logic [MemMapPkg::DataWidth-1:0] outData
);
    import MemMapPkg::*;

    MemExecIf exIf ();

    logic [AddrWidth-1:0] addrOut;
    logic [PhyAddrWidth-1:0] phyAddrOut;
    MemoryMapType memMapType;
    logic uncachable;
    logic [DataWidth-1:0] csrReadData;

    MemExecStage i_MemExecStage (
        .clock(clock),
        .reset(reset),
        .stall(stall),
        .flush(flush),
        .inValid(inValid),
        .inOp(inOp),
        .inOperandA(inOperandA),
        .inOperandB(inOperandB),
        .inOpAValid(inOpAValid),
        .inOpBValid(inOpBValid),
        .exIf(exIf.Stage),
        .addrOut(addrOut),
        .phyAddrOut(phyAddrOut),
        .memMapType(memMapType),
        .uncachable(uncachable),
        .csrReadData(csrReadData),
        .outValid(outValid),
        .regValid(regValid),
        .dcReadReq(dcReadReq),
        .outAddr(outAddr),
        .outPhyAddr(outPhyAddr),
        .outData(outData),
        .outMapType(outMapType),
        .dcReadAddr(dcReadAddr),
        .dcReadUncachable(dcReadUncachable)
    );

    AddressUnit #(
        .IoBase(IoBase),
        .IoSize(IoSize)
    ) i_AddressUnit (
        .exIf(exIf.Address),
        .addrOut(addrOut),
        .phyAddrOut(phyAddrOut),
        .memMapType(memMapType),
        .uncachable(uncachable)
    );

    CsrFile #(
        .CsrCount(CsrCount)
    ) i_CsrFile (
        .clock(clock),
        .reset(reset),
        .exIf(exIf.Csr),
        .csrReadData(csrReadData)
    );

endmodule

`default_nettype wire

// File: tests/MemExec_assertions.sv
////////////////////////////////////////////////////////////////////////////
// Protocol checks bound into every MemExecStage instance. A cache read
// request needs a registered load, and outValid never rises while the
// stage is stalled or flushed.
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module MemExecAssertions (
    input logic clock,
    input logic reset,
    input logic stall,
    input logic flush,
    input logic outValid,
    input logic regValid,
    input logic dcReadReq,
    input logic pipeValid,
    input MemOpPkg::MemOp pipeOp
);
    import MemOpPkg::*;

    // Cache request only for a registered load
    requestNeedsLoad: assert property (@(posedge clock) disable iff (reset)
        dcReadReq |-> (pipeValid && (pipeOp.opType == LOAD)))
        else $error("dcReadReq raised without a registered load");

    // Replayed ops never reach the cache
    requestNeedsOperands: assert property (@(posedge clock) disable iff (reset)
        dcReadReq |-> regValid)
        else $error("dcReadReq raised with a missing operand");

    validNotStalled: assert property (@(posedge clock) disable iff (reset)
        outValid |-> !stall)
        else $error("outValid high during stall");

    validNotFlushed: assert property (@(posedge clock) disable iff (reset)
        outValid |-> !flush)
        else $error("outValid high during flush");

endmodule

bind MemExecStage MemExecAssertions i_MemExecAssertions (
    .clock(clock),
    .reset(reset),
    .stall(stall),
    .flush(flush),
    .outValid(outValid),
    .regValid(regValid),
    .dcReadReq(dcReadReq),
    .pipeValid(pipeValid),
    .pipeOp(pipeOp)
);

`default_nettype wire

// File: tests/MemExecTb.sv
////////////////////////////////////////////////////////////////////////////
// Testbench for the memory execution lane. A reference model tracks the
// registered op and a CSR shadow; concurrent assertions compare against
// it. Inputs change 1 ns after the rising edge.
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module MemExecTb;
    import MemOpPkg::*;
    import MemMapPkg::*;

    localparam logic [AddrWidth-1:0] IoBase = 32'h4000_0000;
    localparam logic [AddrWidth-1:0] IoSize = 32'h0001_0000;
    localparam int CsrCount = 8;
    localparam int CsrIndexWidth = $clog2(CsrCount);
    localparam int ClockPeriod = 4;
    localparam int ResetCycles = 16;
    localparam int RandomCycles = 200;
    localparam int MapCycles = 9;
    localparam int ReplayCycles = 60;
    localparam int CsrCycles = 20;
    localparam int StallCycles = 20;
    localparam int DrainCycles = 3;
    localparam int TotalCycles = ResetCycles + RandomCycles + MapCycles + ReplayCycles
                               + CsrCycles + StallCycles + 5 * DrainCycles;
    localparam int WatchdogNs = (TotalCycles + 50) * ClockPeriod;

    logic clock;
    logic reset;
    logic stall;
    logic flush;
    logic inValid;
    MemOp inOp;
    logic [DataWidth-1:0] inOperandA;
    logic [DataWidth-1:0] inOperandB;
    logic inOpAValid;
    logic inOpBValid;
    logic outValid;
    logic regValid;
    logic dcReadReq;
    logic [PhyAddrWidth-1:0] dcReadAddr;
    logic dcReadUncachable;
    logic [AddrWidth-1:0] outAddr;
    logic [PhyAddrWidth-1:0] outPhyAddr;
    MemoryMapType outMapType;
    logic [DataWidth-1:0] outData;

    // Reference model state
    logic refValid;
    MemOp refOp;
    logic [DataWidth-1:0] refA;
    logic [DataWidth-1:0] refB;
    logic refAValid;
    logic refBValid;
    logic [DataWidth-1:0] shadow [CsrCount];

    logic expOutValid;
    logic expRegValid;
    logic expDcReq;
    logic expMemOp;
    logic [AddrWidth-1:0] expAddr;
    logic [PhyAddrWidth-1:0] expPhyAddr;
    MemoryMapType expMap;
    logic [DataWidth-1:0] expData;
    CsrAccessField csrField;
    logic csrInRange;
    logic [CsrIndexWidth-1:0] csrIndex;
    logic [DataWidth-1:0] csrOld;
    logic [DataWidth-1:0] csrSource;
    logic [DataWidth-1:0] csrNext;
    logic csrCommit;

    int failCount = 0;
    int failsAtStart = 0;
    int testCount = 0;

    MemExecTop #(
        .IoBase(IoBase),
        .IoSize(IoSize),
        .CsrCount(CsrCount)
    ) i_MemExecTop (
        .clock(clock),
        .reset(reset),
        .stall(stall),
        .flush(flush),
        .inValid(inValid),
        .inOp(inOp),
        .inOperandA(inOperandA),
        .inOperandB(inOperandB),
        .inOpAValid(inOpAValid),
        .inOpBValid(inOpBValid),
        .outValid(outValid),
        .regValid(regValid),
        .dcReadReq(dcReadReq),
        .dcReadAddr(dcReadAddr),
        .dcReadUncachable(dcReadUncachable),
        .outAddr(outAddr),
        .outPhyAddr(outPhyAddr),
        .outMapType(outMapType),
        .outData(outData)
    );

    initial begin
        clock = 1'b0;
        forever #(ClockPeriod / 2) clock = ~clock;
    end

    // Map rule with one spare bit so the IO upper bound cannot wrap
    function automatic MemoryMapType classifyAddress(input logic [AddrWidth-1:0] addr);
        logic [AddrWidth:0] wide;
        logic [AddrWidth:0] ioEnd;
        wide = {1'b0, addr};
        ioEnd = {1'b0, IoBase} + {1'b0, IoSize};
        if (addr < MemLimit) begin
            return MMT_MEMORY;
        end
        if ((addr >= IoBase) && (wide < ioEnd)) begin
            return MMT_IO;
        end
        return MMT_ILLEGAL;
    endfunction

    always_comb begin
        expOutValid = refValid && !stall && !flush;
        expRegValid = refAValid && ((refOp.opType != STORE) || refBValid);
        expDcReq = expOutValid && expRegValid && (refOp.opType == LOAD);
        expMemOp = expOutValid && ((refOp.opType == LOAD) || (refOp.opType == STORE));
        expAddr = refA + {{(AddrWidth - 12){refOp.field.mem.offset[11]}},
                          refOp.field.mem.offset};
        expPhyAddr = expAddr[PhyAddrWidth-1:0];
        expMap = classifyAddress(expAddr);

        csrField = refOp.field.csr;
        csrInRange = int'(csrField.csrNumber) < CsrCount;
        csrIndex = csrField.csrNumber[CsrIndexWidth-1:0];
        csrOld = csrInRange ? shadow[csrIndex] : '0;
        csrSource = csrField.isImm ? {{(DataWidth - CsrImmWidth){1'b0}}, csrField.imm} : refA;
        case (csrField.code)
            WRITE: csrNext = csrSource;
            SET: csrNext = csrOld | csrSource;
            CLEAR: csrNext = csrOld & ~csrSource;
            default: csrNext = csrOld;
        endcase
        csrCommit = expOutValid && expRegValid && (refOp.opType == CSR) && csrInRange;
        expData = (refOp.opType == CSR) ? csrOld : refB;
    end

    always @(posedge clock) begin
        if (reset) begin
            refValid <= 1'b0;
            for (int i = 0; i < CsrCount; i++) begin
                shadow[i] <= '0;
            end
        end else begin
            if (csrCommit) begin
                shadow[csrIndex] <= csrNext;
            end
            if (!stall) begin
                refValid <= inValid;
            end else if (flush) begin
                refValid <= 1'b0;
            end
        end
        if (!stall) begin
            refOp <= inOp;
            refA <= inOperandA;
            refB <= inOperandB;
            refAValid <= inOpAValid;
            refBValid <= inOpBValid;
        end
    end

    task automatic noteMismatch(input string name, input logic [31:0] got,
                                input logic [31:0] expected);
        failCount++;
        $display("[FAIL] %s: got %h, expected %h at %0t", name, got, expected, $time);
    endtask

    checkOutValid: assert property (@(posedge clock) disable iff (reset)
        outValid == expOutValid)
        else noteMismatch("outValid", 32'($sampled(outValid)), 32'($sampled(expOutValid)));
    checkRegValid: assert property (@(posedge clock) disable iff (reset)
        refValid |-> (regValid == expRegValid))
        else noteMismatch("regValid", 32'($sampled(regValid)), 32'($sampled(expRegValid)));
    checkDcReq: assert property (@(posedge clock) disable iff (reset)
        dcReadReq == expDcReq)
        else noteMismatch("dcReadReq", 32'($sampled(dcReadReq)), 32'($sampled(expDcReq)));
    checkAddr: assert property (@(posedge clock) disable iff (reset)
        expMemOp |-> (outAddr == expAddr))
        else noteMismatch("outAddr", $sampled(outAddr), $sampled(expAddr));
    checkPhyAddr: assert property (@(posedge clock) disable iff (reset)
        expMemOp |-> (outPhyAddr == expPhyAddr))
        else noteMismatch("outPhyAddr", 32'($sampled(outPhyAddr)), 32'($sampled(expPhyAddr)));
    checkDcAddr: assert property (@(posedge clock) disable iff (reset)
        expDcReq |-> (dcReadAddr == expPhyAddr))
        else noteMismatch("dcReadAddr", 32'($sampled(dcReadAddr)), 32'($sampled(expPhyAddr)));
    checkMapType: assert property (@(posedge clock) disable iff (reset)
        expMemOp |-> (outMapType == expMap))
        else noteMismatch("outMapType", 32'($sampled(outMapType)), 32'($sampled(expMap)));
    checkUncachable: assert property (@(posedge clock) disable iff (reset)
        expMemOp |-> (dcReadUncachable == (expMap == MMT_IO)))
        else noteMismatch("dcReadUncachable", 32'($sampled(dcReadUncachable)),
                          32'($sampled(expMap == MMT_IO)));
    checkData: assert property (@(posedge clock) disable iff (reset)
        expOutValid |-> (outData == expData))
        else noteMismatch("outData", $sampled(outData), $sampled(expData));

    task automatic tick();
        @(posedge clock);
        #1;
    endtask

    task automatic setMem(input MemOpType kind, input logic [11:0] offset,
                          input logic [31:0] a, input logic [31:0] b,
                          input logic aValid, input logic bValid);
        inValid = 1'b1;
        inOp = '0;
        inOp.opType = kind;
        inOp.field.mem.offset = offset;
        inOperandA = a;
        inOperandB = b;
        inOpAValid = aValid;
        inOpBValid = bValid;
    endtask

    task automatic setCsr(input CsrCode code, input logic [11:0] number,
                          input logic isImm, input logic [4:0] imm, input logic [31:0] a);
        inValid = 1'b1;
        inOp = '0;
        inOp.opType = CSR;
        inOp.field.csr.csrNumber = number;
        inOp.field.csr.code = code;
        inOp.field.csr.isImm = isImm;
        inOp.field.csr.imm = imm;
        inOperandA = a;
        inOperandB = 32'h0;
        inOpAValid = 1'b1;
        inOpBValid = 1'b1;
    endtask

    task automatic setIdle();
        inValid = 1'b0;
        inOp.opType = NOP;
    endtask

    task automatic endTest(input string name);
        setIdle();
        stall = 1'b0;
        flush = 1'b0;
        repeat (DrainCycles) tick();
        testCount++;
        if (failCount == failsAtStart) begin
            $display("%s: no mismatches", name);
        end else begin
            $display("%s: %0d mismatches", name, failCount - failsAtStart);
        end
        failsAtStart = failCount;
    endtask

    // Watchdog sized from the test lengths
    initial begin
        #(WatchdogNs);
        $display("Watchdog expired after %0d ns, the run did not finish", WatchdogNs);
        $display("Test failed");
        $finish;
    end

    initial begin
        logic [31:0] rnd;
        logic [31:0] base;
        void'($urandom(32'h3405_da99));
        reset = 1'b1;
        stall = 1'b0;
        flush = 1'b0;
        inValid = 1'b0;
        inOp = '0;
        inOperandA = '0;
        inOperandB = '0;
        inOpAValid = 1'b0;
        inOpBValid = 1'b0;
        repeat (ResetCycles) @(posedge clock);
        #1;
        reset = 1'b0;

        // Random loads and stores over all regions
        for (int i = 0; i < RandomCycles; i++) begin
            rnd = $urandom;
            base = $urandom;
            if (rnd[1:0] == 2'd2) begin
                base = IoBase + {16'h0, base[15:0]};
            end else if (rnd[1:0] != 2'd3) begin
                base = {8'h00, base[23:0]};
            end
            setMem(rnd[2] ? STORE : LOAD, rnd[14:3], base, $urandom, 1'b1, 1'b1);
            tick();
        end
        endTest("random loads/stores");

        // Edges of the memory map
        setMem(LOAD, 12'h010, 32'h0000_1000, 32'h1, 1'b1, 1'b1);
        tick();
        setMem(LOAD, 12'hfff, MemLimit, 32'h2, 1'b1, 1'b1);
        tick();
        setMem(STORE, 12'h000, MemLimit, 32'h3, 1'b1, 1'b1);
        tick();
        setMem(LOAD, 12'hffc, IoBase + 32'h100, 32'h4, 1'b1, 1'b1);
        tick();
        setMem(LOAD, 12'h000, IoBase + IoSize - 32'h1, 32'h5, 1'b1, 1'b1);
        tick();
        setMem(STORE, 12'h001, IoBase + IoSize - 32'h1, 32'h6, 1'b1, 1'b1);
        tick();
        setMem(LOAD, 12'hfff, IoBase, 32'h7, 1'b1, 1'b1);
        tick();
        setMem(LOAD, 12'hfff, 32'h0, 32'h8, 1'b1, 1'b1);
        tick();
        setMem(LOAD, 12'h7ff, 32'h8000_0000, 32'h9, 1'b1, 1'b1);
        tick();
        endTest("map classification");

        // Missing operands mixed with random stall and flush
        for (int i = 0; i < ReplayCycles; i++) begin
            rnd = $urandom;
            base = $urandom;
            setMem(rnd[0] ? STORE : LOAD, rnd[22:11], {8'h00, base[23:0]}, $urandom,
                   rnd[1] | rnd[2], rnd[3] | rnd[4]);
            stall = (rnd[7:5] == 3'd0);
            flush = (rnd[10:8] == 3'd0);
            tick();
        end
        endTest("replay");

        // Directed CSR sequence, then random ones
        setCsr(WRITE, 12'd1, 1'b0, 5'h00, 32'hdead_beef);
        tick();
        setCsr(SET, 12'd1, 1'b1, 5'h11, 32'h0);
        tick();
        setCsr(CLEAR, 12'd1, 1'b0, 5'h00, 32'h0000_00ff);
        tick();
        setCsr(SET, 12'd1, 1'b1, 5'h00, 32'h0);
        tick();
        setCsr(WRITE, 12'd9, 1'b0, 5'h00, 32'h1234_5678);
        tick();
        setCsr(SET, 12'd9, 1'b1, 5'h00, 32'h0);
        tick();
        setCsr(CLEAR, 12'd3, 1'b1, 5'h1f, 32'h0);
        tick();
        setCsr(WRITE, 12'hfff, 1'b1, 5'h03, 32'h0);
        tick();
        for (int i = 0; i < CsrCycles - 8; i++) begin
            rnd = $urandom;
            setCsr((rnd[1:0] == 2'd0) ? WRITE : ((rnd[1:0] == 2'd1) ? SET : CLEAR),
                   {8'h00, rnd[11:8]}, rnd[12], rnd[17:13], $urandom);
            tick();
        end
        endTest("CSR operations");

        // Held load reappears after a stall
        setMem(LOAD, 12'h008, 32'h0000_0100, 32'h0, 1'b1, 1'b1);
        tick();
        stall = 1'b1;
        setMem(STORE, 12'h020, 32'h0000_2000, 32'hcafe_f00d, 1'b1, 1'b1);
        repeat (3) tick();
        stall = 1'b0;
        setIdle();
        tick();
        // Flushed CSR write must not land
        setCsr(WRITE, 12'd2, 1'b0, 5'h00, 32'h0000_1234);
        tick();
        flush = 1'b1;
        setIdle();
        tick();
        flush = 1'b0;
        setCsr(SET, 12'd2, 1'b1, 5'h00, 32'h0);
        tick();
        // Flushed load raises no cache request
        setMem(LOAD, 12'h004, 32'h0000_0400, 32'h0, 1'b1, 1'b1);
        tick();
        flush = 1'b1;
        setIdle();
        tick();
        flush = 1'b0;
        // Flush during stall drops the held op
        setMem(LOAD, 12'h00c, 32'h0000_0800, 32'h0, 1'b1, 1'b1);
        tick();
        stall = 1'b1;
        setIdle();
        tick();
        flush = 1'b1;
        tick();
        stall = 1'b0;
        flush = 1'b0;
        tick();
        for (int i = 0; i < StallCycles - 14; i++) begin
            rnd = $urandom;
            setMem(LOAD, rnd[11:0], {8'h00, rnd[31:8]}, 32'h0, 1'b1, 1'b1);
            stall = rnd[12];
            tick();
        end
        endTest("stall and flush");

        $display("Summary: %0d tests run, %0d failed checks", testCount, failCount);
        if (failCount == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
src/MemOpPkg.sv
src/MemMapPkg.sv
src/MemExecIf.sv
src/AddressUnit.sv
src/CsrFile.sv
src/MemExecStage.sv
src/MemExecTop.sv
tests/MemExec_assertions.sv
tests/MemExecTb.sv

// File: run.sh
#!/bin/sh
# Build the testbench with Verilator, run it and decide pass or fail from the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir
BINARY=simMemExec

if ! verilator --binary --timing --assert \
        --top-module MemExecTb \
        -f all.f \
        -Mdir "$BUILD_DIR" -o "$BINARY"; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/$BINARY" > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "Test passed" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1
